// File: hw/oflow_pkg.sv
package oflow_pkg;

  // field widths
  localparam int ID_LEN     = 8;
  localparam int COORD_LEN  = 10;  // coordinates and box sizes
  localparam int COLOR_LEN  = 12;
  localparam int METRIC_LEN = 14;  // six abs diffs, worst case 12282

  // row address carried by a command, top level may use fewer bits
  localparam int MAX_ADDR_WIDTH = 8;

  // slice 0: id and centre of mass, 28 bits
  typedef struct packed {
    logic [ID_LEN-1:0]    id;
    logic [COORD_LEN-1:0] cm_x;
    logic [COORD_LEN-1:0] cm_y;
  } idcm_t;

  // slice 1: corners, 40 bits
  typedef struct packed {
    logic [COORD_LEN-1:0] tl_x;  // top left
    logic [COORD_LEN-1:0] tl_y;
    logic [COORD_LEN-1:0] br_x;  // bottom right
    logic [COORD_LEN-1:0] br_y;
  } pos_t;

  // slice 2: size and colour, 44 bits
  typedef struct packed {
    logic [COORD_LEN-1:0] width;
    logic [COORD_LEN-1:0] height;
    logic [COLOR_LEN-1:0] color1;
    logic [COLOR_LEN-1:0] color2;
  } attr_t;

  // full feature record, 112 bits
  typedef struct packed {
    idcm_t idcm;
    pos_t  pos;
    attr_t attr;
  } bbox_feat_t;

  // one memory row, left record in the upper half
  typedef struct packed {
    bbox_feat_t left;
    bbox_feat_t right;
  } row_t;

  typedef enum logic [1:0] {
    OP_NOP        = 2'd0,
    OP_WRITE_PAIR = 2'd1,  // row_0 -> even row, row_1 -> odd row
    OP_MATCH      = 2'd2,  // row_0.left is the query
    OP_RSVD       = 2'd3   // flagged as error
  } op_e;

  typedef struct packed {
    op_e                     op;
    logic [MAX_ADDR_WIDTH-1:0] addr;
    row_t                    row_0;
    row_t                    row_1;
  } oflow_cmd_t;

  // match result, 24 bits
  typedef struct packed {
    logic [ID_LEN-1:0]     best_id;
    logic [METRIC_LEN-1:0] metric;
    logic                  side;   // 0 left, 1 right
    logic                  found;  // metric within threshold
  } match_res_t;

endpackage

// File: hw/feature_bank.sv
module feature_bank #(
  parameter type payload_t  = logic [63:0],
  parameter int  ADDR_WIDTH = 8
) (
  input  logic                  clk,
  // port 0, write or read
  input  logic                  we_0,
  input  logic [ADDR_WIDTH-1:0] addr_0,
  input  payload_t              wdata_0,
  output payload_t              rdata_0,
  // port 1, write only
  input  logic                  we_1,
  input  logic [ADDR_WIDTH-1:0] addr_1,
  input  payload_t              wdata_1
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  payload_t mem [DEPTH];  // contents undefined until written

  always_ff @(posedge clk) begin
    if (we_0) begin
      mem[addr_0] <= wdata_0;
    end else begin
      rdata_0 <= mem[addr_0];  // registered read, one cycle
    end
  end

  // second write port, never read
  always_ff @(posedge clk) begin
    if (we_1) begin
      mem[addr_1] <= wdata_1;
    end
  end

  // a same-address double write has no defined winner
  a_no_write_collision: assert property (
    @(posedge clk) !(we_0 && we_1 && (addr_0 == addr_1))
  ) else $error("feature_bank: both ports write address %0d", addr_0);

endmodule

// File: hw/feature_mem.sv
module feature_mem #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr_0,  // even row
  input  logic [ADDR_WIDTH-1:0] wr_addr_1,  // odd row
  input  oflow_pkg::row_t       wr_row_0,
  input  oflow_pkg::row_t       wr_row_1,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output oflow_pkg::row_t       rd_row      // valid the cycle after rd_en
);

  localparam int NUM_SIDES = 2;  // left and right record

  logic [ADDR_WIDTH-1:0] addr_p0;

  // write data split per side
  oflow_pkg::bbox_feat_t wr_rec_0 [NUM_SIDES];
  oflow_pkg::bbox_feat_t wr_rec_1 [NUM_SIDES];

  // port 0 read data per side and slice
  oflow_pkg::idcm_t rd_idcm [NUM_SIDES];
  oflow_pkg::pos_t  rd_pos  [NUM_SIDES];
  oflow_pkg::attr_t rd_attr [NUM_SIDES];

  assign addr_p0 = rd_en ? rd_addr : wr_addr_0;  // port 0 shared by read and write

  assign wr_rec_0[0] = wr_row_0.left;
  assign wr_rec_0[1] = wr_row_0.right;
  assign wr_rec_1[0] = wr_row_1.left;
  assign wr_rec_1[1] = wr_row_1.right;

  // side 0 gives banks 0..2 (left), side 1 gives banks 3..5 (right)
  for (genvar s = 0; s < NUM_SIDES; s++) begin : g_side
    feature_bank #(
      .payload_t  (oflow_pkg::idcm_t),
      .ADDR_WIDTH (ADDR_WIDTH)
    ) u_bank_idcm (
      .clk     (clk),
      .we_0    (wr_en),
      .addr_0  (addr_p0),
      .wdata_0 (wr_rec_0[s].idcm),
      .rdata_0 (rd_idcm[s]),
      .we_1    (wr_en),
      .addr_1  (wr_addr_1),
      .wdata_1 (wr_rec_1[s].idcm)
    );

    feature_bank #(
      .payload_t  (oflow_pkg::pos_t),
      .ADDR_WIDTH (ADDR_WIDTH)
    ) u_bank_pos (
      .clk     (clk),
      .we_0    (wr_en),
      .addr_0  (addr_p0),
      .wdata_0 (wr_rec_0[s].pos),
      .rdata_0 (rd_pos[s]),
      .we_1    (wr_en),
      .addr_1  (wr_addr_1),
      .wdata_1 (wr_rec_1[s].pos)
    );

    feature_bank #(
      .payload_t  (oflow_pkg::attr_t),
      .ADDR_WIDTH (ADDR_WIDTH)
    ) u_bank_attr (
      .clk     (clk),
      .we_0    (wr_en),
      .addr_0  (addr_p0),
      .wdata_0 (wr_rec_0[s].attr),
      .rdata_0 (rd_attr[s]),
      .we_1    (wr_en),
      .addr_1  (wr_addr_1),
      .wdata_1 (wr_rec_1[s].attr)
    );
  end

  // reassemble, left record on top
  assign rd_row = {rd_idcm[0], rd_pos[0], rd_attr[0],
                   rd_idcm[1], rd_pos[1], rd_attr[1]};

  // port 0 can serve only one of them per cycle
  a_no_rw_overlap: assert property (
    @(posedge clk) !(wr_en && rd_en)
  ) else $error("feature_mem: write and read in the same cycle");

endmodule

// File: hw/cmd_decode.sv
module cmd_decode #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmd_valid,
  input  oflow_pkg::oflow_cmd_t cmd,
  // to feature_mem
  output logic                  wr_en,
  output logic [ADDR_WIDTH-1:0] wr_addr_0,
  output logic [ADDR_WIDTH-1:0] wr_addr_1,
  output oflow_pkg::row_t       wr_row_0,
  output oflow_pkg::row_t       wr_row_1,
  output logic                  rd_en,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  // to similarity_calc
  output logic                  match_v,
  output oflow_pkg::bbox_feat_t match_q,
  output logic                  cmd_err
);

  logic                  is_write;
  logic                  is_match;
  logic                  is_rsvd;
  logic [ADDR_WIDTH-1:0] row_addr;

  if (ADDR_WIDTH > oflow_pkg::MAX_ADDR_WIDTH) begin : g_addr_check
    $error("cmd_decode: ADDR_WIDTH exceeds the command address field");
  end

  // opcode decode, qualified by the strobe
  assign is_write = cmd_valid && (cmd.op == oflow_pkg::OP_WRITE_PAIR);
  assign is_match = cmd_valid && (cmd.op == oflow_pkg::OP_MATCH);
  assign is_rsvd  = cmd_valid && (cmd.op == oflow_pkg::OP_RSVD);
  assign row_addr = cmd.addr[ADDR_WIDTH-1:0];

  // strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en   <= 1'b0;
      rd_en   <= 1'b0;
      match_v <= 1'b0;
      cmd_err <= 1'b0;
    end else begin
      wr_en   <= is_write;
      rd_en   <= is_match;
      match_v <= is_match;  // travels with rd_en
      cmd_err <= is_rsvd;   // one cycle pulse, nothing else happens
    end
  end

  // payload, held between commands
  always_ff @(posedge clk) begin
    if (is_write) begin
      wr_addr_0 <= {row_addr[ADDR_WIDTH-1:1], 1'b0};  // pair always starts even
      wr_addr_1 <= {row_addr[ADDR_WIDTH-1:1], 1'b1};
      wr_row_0  <= cmd.row_0;
      wr_row_1  <= cmd.row_1;
    end
    if (is_match) begin
      rd_addr <= row_addr;
      match_q <= cmd.row_0.left;  // query record
    end
  end

  a_strobes_known: assert property (
    @(posedge clk) disable iff (rst) !$isunknown({wr_en, rd_en, match_v, cmd_err})
  ) else $error("cmd_decode: unknown output strobe");

endmodule

// File: hw/similarity_calc.sv
module similarity_calc #(
  parameter int MATCH_THRESH = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  match_v,
  input  oflow_pkg::bbox_feat_t match_q,
  input  oflow_pkg::row_t       rd_row,   // one cycle behind match_v
  output logic                  res_valid,
  output oflow_pkg::match_res_t res
);

  localparam int DIFF_LEN = oflow_pkg::COLOR_LEN;  // widest field

  logic                                q_v;      // match_v delayed to rd_row
  oflow_pkg::bbox_feat_t               q_rec;
  logic [oflow_pkg::METRIC_LEN-1:0]    metric_l;
  logic [oflow_pkg::METRIC_LEN-1:0]    metric_r;
  logic [oflow_pkg::METRIC_LEN-1:0]    best_metric;
  logic                                best_side;
  logic [oflow_pkg::ID_LEN-1:0]        best_id;

  // |a - b| on zero-extended fields
  function automatic logic [DIFF_LEN-1:0] abs_diff(
    input logic [DIFF_LEN-1:0] a,
    input logic [DIFF_LEN-1:0] b
  );
    return (a >= b) ? (a - b) : (b - a);
  endfunction

  // L1 over centre, size and colour only
  function automatic logic [oflow_pkg::METRIC_LEN-1:0] l1_metric(
    input oflow_pkg::bbox_feat_t q,
    input oflow_pkg::bbox_feat_t s
  );
    logic [oflow_pkg::METRIC_LEN-1:0] sum;
    sum = '0;
    sum += oflow_pkg::METRIC_LEN'(abs_diff(DIFF_LEN'(q.idcm.cm_x), DIFF_LEN'(s.idcm.cm_x)));
    sum += oflow_pkg::METRIC_LEN'(abs_diff(DIFF_LEN'(q.idcm.cm_y), DIFF_LEN'(s.idcm.cm_y)));
    sum += oflow_pkg::METRIC_LEN'(abs_diff(DIFF_LEN'(q.attr.width), DIFF_LEN'(s.attr.width)));
    sum += oflow_pkg::METRIC_LEN'(abs_diff(DIFF_LEN'(q.attr.height), DIFF_LEN'(s.attr.height)));
    sum += oflow_pkg::METRIC_LEN'(abs_diff(q.attr.color1, s.attr.color1));
    sum += oflow_pkg::METRIC_LEN'(abs_diff(q.attr.color2, s.attr.color2));
    return sum;  // max 12282 so it never wraps
  endfunction

  // stage 1 aligns query with bank read data
  always_ff @(posedge clk) begin
    if (rst) begin
      q_v <= 1'b0;
    end else begin
      q_v <= match_v;
    end
  end

  always_ff @(posedge clk) begin
    if (match_v) begin
      q_rec <= match_q;
    end
  end

  // both sides in parallel
  assign metric_l = l1_metric(q_rec, rd_row.left);
  assign metric_r = l1_metric(q_rec, rd_row.right);

  // right wins only when strictly better so ties stay left
  assign best_side   = (metric_r < metric_l);
  assign best_metric = best_side ? metric_r : metric_l;
  assign best_id     = best_side ? rd_row.right.idcm.id : rd_row.left.idcm.id;

  // stage 2 result register
  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= q_v;
    end
  end

  always_ff @(posedge clk) begin
    if (q_v) begin
      res.best_id <= best_id;
      res.metric  <= best_metric;
      res.side    <= best_side;
      res.found   <= (best_metric <= oflow_pkg::METRIC_LEN'(MATCH_THRESH));
    end
  end

endmodule

// File: hw/oflow_match_top.sv
module oflow_match_top #(
  parameter int ADDR_WIDTH   = 8,
  parameter int MATCH_THRESH = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmd_valid,
  input  oflow_pkg::oflow_cmd_t cmd,
  output logic                  res_valid,
  output oflow_pkg::match_res_t res,
  output logic                  cmd_err    // reserved opcode seen
);

  // decode to memory
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr_0;
  logic [ADDR_WIDTH-1:0] wr_addr_1;
  oflow_pkg::row_t       wr_row_0;
  oflow_pkg::row_t       wr_row_1;
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  // decode to matcher
  logic                  match_v;
  oflow_pkg::bbox_feat_t match_q;
  // memory to matcher
  oflow_pkg::row_t       rd_row;

  cmd_decode #(.ADDR_WIDTH(ADDR_WIDTH)) u_cmd_decode (  // stage 1
    .clk, .rst, .cmd_valid, .cmd,
    .wr_en, .wr_addr_0, .wr_addr_1, .wr_row_0, .wr_row_1,
    .rd_en, .rd_addr, .match_v, .match_q, .cmd_err
  );

  feature_mem #(.ADDR_WIDTH(ADDR_WIDTH)) u_feature_mem (  // stage 2
    .clk, .wr_en, .wr_addr_0, .wr_addr_1, .wr_row_0, .wr_row_1,
    .rd_en, .rd_addr, .rd_row
  );

  similarity_calc #(.MATCH_THRESH(MATCH_THRESH)) u_similarity_calc (  // stage 3
    .clk, .rst, .match_v, .match_q, .rd_row, .res_valid, .res
  );

endmodule

// File: dv/oflow_match_tb.sv
module oflow_match_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_WIDTH   = 8;
  localparam int MATCH_THRESH = 64;
  localparam int RESET_CYCLES = 8;
  localparam int TEST_CYCLES  = 6 * 30;  // six tests each well under 30 cycles with drain
  localparam int MARGIN       = 60;
  localparam int TIMEOUT      = RESET_CYCLES + TEST_CYCLES + MARGIN;
  localparam int LATENCY      = 4;  // monitor cycles from issue edge to result
  localparam int ERR_LATENCY  = 2;

  logic                  clk;
  logic                  rst;
  logic                  cmd_valid;
  oflow_pkg::oflow_cmd_t cmd;
  logic                  res_valid;
  oflow_pkg::match_res_t res;
  logic                  cmd_err;

  oflow_pkg::row_t       model_mem [1 << ADDR_WIDTH];  // reference copy of stored rows
  oflow_pkg::match_res_t exp_res_q [$];
  int                    exp_cyc_q [$];                 // monitor cycle each result is due
  int                    err_cyc_q [$];
  int                    cycle = 0;
  int                    wd_cycles = 0;
  int                    check_cnt = 0;
  int                    err_cnt = 0;
  logic [31:0]           lfsr = 32'h4b50;

  oflow_match_top #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .MATCH_THRESH (MATCH_THRESH)
  ) oflow_match_top_i (
    .clk, .rst, .cmd_valid, .cmd, .res_valid, .res, .cmd_err
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic oflow_pkg::bbox_feat_t rand_feat();
    oflow_pkg::bbox_feat_t f;
    f.idcm.id      = rand_bits(8);
    f.idcm.cm_x    = rand_bits(10);
    f.idcm.cm_y    = rand_bits(10);
    f.pos.tl_x     = rand_bits(10);
    f.pos.tl_y     = rand_bits(10);
    f.pos.br_x     = rand_bits(10);
    f.pos.br_y     = rand_bits(10);
    f.attr.width   = rand_bits(10);
    f.attr.height  = rand_bits(10);
    f.attr.color1  = rand_bits(11);  // headroom for query offsets
    f.attr.color2  = rand_bits(12);
    return f;
  endfunction

  function automatic oflow_pkg::row_t rand_row();
    oflow_pkg::row_t r;
    r.left  = rand_feat();
    r.right = rand_feat();
    return r;
  endfunction

  // right record = left with another id and color1 1000 higher
  function automatic oflow_pkg::row_t near_row();
    oflow_pkg::row_t r;
    r.left              = rand_feat();
    r.right             = r.left;
    r.right.idcm.id     = r.left.idcm.id + 8'd1;
    r.right.attr.color1 = r.left.attr.color1 + 12'd1000;
    return r;
  endfunction

  function automatic int abs_diff_int(input int a, input int b);
    return (a > b) ? a - b : b - a;
  endfunction

  function automatic int model_metric(input oflow_pkg::bbox_feat_t q,
                                      input oflow_pkg::bbox_feat_t s);
    int m;
    m = abs_diff_int(int'(q.idcm.cm_x), int'(s.idcm.cm_x));
    m = m + abs_diff_int(int'(q.idcm.cm_y), int'(s.idcm.cm_y));
    m = m + abs_diff_int(int'(q.attr.width), int'(s.attr.width));
    m = m + abs_diff_int(int'(q.attr.height), int'(s.attr.height));
    m = m + abs_diff_int(int'(q.attr.color1), int'(s.attr.color1));
    m = m + abs_diff_int(int'(q.attr.color2), int'(s.attr.color2));
    return m;
  endfunction

  function automatic oflow_pkg::match_res_t model_match(input oflow_pkg::bbox_feat_t q,
                                                        input oflow_pkg::row_t r);
    oflow_pkg::match_res_t e;
    int                    ml;
    int                    mr;
    int                    m;
    ml = model_metric(q, r.left);
    mr = model_metric(q, r.right);
    e.side    = (mr < ml);  // right only when strictly closer
    m         = e.side ? mr : ml;
    e.metric  = m;
    e.best_id = e.side ? r.right.idcm.id : r.left.idcm.id;
    e.found   = (m <= MATCH_THRESH);
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
    check_cnt++;
    if (exp_v !== got_v) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp_v, got_v);
    end
  endtask

  // one command per rising edge plus model and expectation update
  task automatic issue(input oflow_pkg::op_e op, input logic [7:0] addr,
                       input oflow_pkg::row_t r0, input oflow_pkg::row_t r1);
    oflow_pkg::oflow_cmd_t c;
    @(posedge clk);
    c.op    = op;
    c.addr  = addr;
    c.row_0 = r0;
    c.row_1 = r1;
    cmd_valid <= 1'b1;
    cmd       <= c;
    if (op == oflow_pkg::OP_WRITE_PAIR) begin
      model_mem[{addr[7:1], 1'b0}] = r0;  // even row through port 0
      model_mem[{addr[7:1], 1'b1}] = r1;
    end else if (op == oflow_pkg::OP_MATCH) begin
      exp_res_q.push_back(model_match(r0.left, model_mem[addr]));
      exp_cyc_q.push_back(cycle + LATENCY);
    end else if (op == oflow_pkg::OP_RSVD) begin
      err_cyc_q.push_back(cycle + ERR_LATENCY);
    end
  endtask

  task automatic match(input logic [7:0] addr, input oflow_pkg::bbox_feat_t q);
    oflow_pkg::row_t r;
    r      = rand_row();
    r.left = q;  // query rides in row_0.left
    issue(oflow_pkg::OP_MATCH, addr, r, rand_row());
  endtask

  // stop driving and wait for every outstanding response
  task automatic drain();
    @(posedge clk);
    cmd_valid <= 1'b0;
    while (exp_cyc_q.size() != 0 || err_cyc_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  // sample mid cycle away from the drive edge
  always @(negedge clk) begin : monitor
    oflow_pkg::match_res_t e;
    cycle++;
    if (!rst) begin
      while (exp_cyc_q.size() != 0 && exp_cyc_q[0] < cycle) begin
        err_cnt++;
        $display("no match result arrived in cycle %0d at %0t", exp_cyc_q[0], $time);
        void'(exp_cyc_q.pop_front());
        void'(exp_res_q.pop_front());
      end
      if (res_valid) begin
        if (exp_cyc_q.size() == 0 || exp_cyc_q[0] != cycle) begin
          err_cnt++;
          $display("res_valid rose with no match due at %0t", $time);
        end else begin
          e = exp_res_q.pop_front();
          void'(exp_cyc_q.pop_front());
          check_field("res.best_id", e.best_id, res.best_id);
          check_field("res.metric", e.metric, res.metric);
          check_field("res.side", e.side, res.side);
          check_field("res.found", e.found, res.found);
        end
      end
      while (err_cyc_q.size() != 0 && err_cyc_q[0] < cycle) begin
        err_cnt++;
        $display("cmd_err missing for the reserved opcode at %0t", $time);
        void'(err_cyc_q.pop_front());
      end
      if (cmd_err) begin
        check_cnt++;
        if (err_cyc_q.size() == 0 || err_cyc_q[0] != cycle) begin
          err_cnt++;
          $display("cmd_err pulsed with no reserved opcode at %0t", $time);
        end else begin
          void'(err_cyc_q.pop_front());
        end
      end
    end
  end

  task automatic test_write_match();
    oflow_pkg::row_t r0;
    oflow_pkg::row_t r1;
    r0 = rand_row();
    r1 = rand_row();
    issue(oflow_pkg::OP_WRITE_PAIR, 8'h10, r0, r1);
    match(8'h10, r0.left);  // exact left hit gives metric 0
    match(8'h11, r1.left);
    drain();
  endtask

  task automatic test_pair_addr();
    oflow_pkg::row_t r0;
    oflow_pkg::row_t r1;
    r0 = rand_row();
    r1 = rand_row();
    r0.left.idcm.id = 8'ha4;
    r1.left.idcm.id = 8'ha5;
    issue(oflow_pkg::OP_WRITE_PAIR, 8'h25, r0, r1);  // odd address lands at 0x24/0x25
    match(8'h24, r0.left);
    match(8'h25, r1.left);
    match(8'h10, model_mem[8'h10].left);  // earlier pair untouched
    drain();
  endtask

  task automatic test_side_tie();
    oflow_pkg::row_t       r;
    oflow_pkg::bbox_feat_t q;
    r = near_row();
    issue(oflow_pkg::OP_WRITE_PAIR, 8'h30, r, rand_row());
    match(8'h30, r.right);  // exact right
    q = r.right;
    q.attr.color1 = q.attr.color1 - 12'd100;  // 900 vs 100
    match(8'h30, q);
    q = r.left;
    q.attr.color1 = q.attr.color1 + 12'd500;  // 500 each side so left is kept
    match(8'h30, q);
    drain();
  endtask

  task automatic test_threshold();
    oflow_pkg::row_t       r;
    oflow_pkg::bbox_feat_t q;
    r = near_row();
    issue(oflow_pkg::OP_WRITE_PAIR, 8'h32, r, rand_row());
    q = r.left;
    q.attr.color1 = q.attr.color1 + 12'(MATCH_THRESH);  // right sits at 1000 - 64
    match(8'h32, q);
    q.attr.color1 = q.attr.color1 + 12'd1;  // one past
    match(8'h32, q);
    drain();
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 4; i++) begin
      issue(oflow_pkg::OP_WRITE_PAIR, 8'h40 + 8'(2 * i), rand_row(), rand_row());
    end
    // first match follows the last write directly
    for (int i = 0; i < 8; i++) begin
      match(8'h47 - 8'(i), (i % 2 == 0) ? model_mem[8'h47 - 8'(i)].right : rand_feat());
    end
    drain();
  endtask

  task automatic test_reserved();
    issue(oflow_pkg::OP_RSVD, 8'h10, rand_row(), rand_row());
    issue(oflow_pkg::OP_NOP, 8'h24, rand_row(), rand_row());
    issue(oflow_pkg::OP_RSVD, 8'h24, rand_row(), rand_row());
    match(8'h24, model_mem[8'h24].left);  // model unchanged by either
    match(8'h10, model_mem[8'h10].left);
    drain();
  endtask

  initial begin
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_field("res_valid", 1'b0, res_valid);
    check_field("cmd_err", 1'b0, cmd_err);
    test_write_match();
    test_pair_addr();
    test_side_tie();
    test_threshold();
    test_back_to_back();
    test_reserved();
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    while (wd_cycles < TIMEOUT) begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("run stopped after %0d cycles, tests did not finish", wd_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: all.f
hw/oflow_pkg.sv
hw/feature_bank.sv
hw/feature_mem.sv
hw/cmd_decode.sv
hw/similarity_calc.sv
hw/oflow_match_top.sv
dv/oflow_match_tb.sv

// File: Bender.yml
package:
  name: oflow_match

sources:
  - files:
      - hw/oflow_pkg.sv
      - hw/feature_bank.sv
      - hw/feature_mem.sv
      - hw/cmd_decode.sv
      - hw/similarity_calc.sv
      - hw/oflow_match_top.sv
  - target: test
    files:
      - dv/oflow_match_tb.sv
